// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_system_tb
FILELIST  ?= cpu_system.f
SEED      ?= 53802
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: cpu_system.f
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_decoder.sv
hw/cpu_datapath.sv
hw/cpu_core.sv
hw/mem_arbiter.sv
hw/sys_ram.sv
hw/cpu_system.sv
tb/cpu_system_tb.sv

// File: hw/cpu_alu.sv
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    input  alu_op_e i_op,
    input  byte_t   i_a,
    input  byte_t   i_b,
    input  logic    i_carry,
    output byte_t   o_result,
    output logic    o_carry,
    output logic    o_overflow
);

    logic [8:0] sum;

    assign sum = {1'b0, i_a} + {1'b0, i_b} + {8'h00, i_carry};

    always_comb begin
        o_result = i_a;
        o_carry = i_carry;
        o_overflow = 1'b0;
        case (i_op)
            ALU_SUM: begin
                o_result = sum[7:0];
                o_carry = sum[8];
                // Signed overflow when both operands agree in sign and the sum does not
                o_overflow = (i_a[7] == i_b[7]) && (sum[7] != i_a[7]);
            end
            ALU_AND: o_result = i_a & i_b;
            ALU_OR: o_result = i_a | i_b;
            ALU_EOR: o_result = i_a ^ i_b;
            ALU_SHR: begin
                o_result = {i_carry, i_a[7:1]};
                o_carry = i_a[0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`default_nettype none

module cpu_core
    import cpu_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_grant,
    input  byte_t      i_rdata,
    output mem_req_t   o_req,
    output logic       o_sync,
    output logic       o_error,
    output cpu_debug_t o_debug
);

    ctrl_t      ctrl;
    byte_t      p;
    byte_t      ir;
    cpu_debug_t dp_debug;

    // Step counter, IR and control decode
    cpu_decoder decoder_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_grant (i_grant),
        .i_rdata (i_rdata),
        .i_p     (p),
        .o_ctrl  (ctrl),
        .o_sync  (o_sync),
        .o_error (o_error),
        .o_ir    (ir)
    );

    // Registers, flags, ALU and request address
    cpu_datapath datapath_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_grant (i_grant),
        .i_ctrl  (ctrl),
        .i_rdata (i_rdata),
        .o_req   (o_req),
        .o_p     (p),
        .o_debug (dp_debug)
    );

    always_comb begin
        o_debug = dp_debug;
        o_debug.ir = ir;
    end

endmodule

`default_nettype wire

// File: hw/cpu_datapath.sv
`default_nettype none

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_grant,
    input  ctrl_t      i_ctrl,
    input  byte_t      i_rdata,
    output mem_req_t   o_req,
    output byte_t      o_p,
    output cpu_debug_t o_debug
);

    byte_t ac;
    byte_t x;
    byte_t dl;
    byte_t mem_data;
    byte_t alu_a;
    byte_t alu_result;
    addr_t pc;
    addr_t pc_base;
    addr_t adr;
    addr_t oper_addr;
    logic  rd_valid;
    logic  flag_n;
    logic  flag_z;
    logic  flag_c;
    logic  flag_v;
    logic  alu_carry;
    logic  alu_ovf;

    // Fresh RAM data right after a granted read, the latched copy later on
    assign mem_data = rd_valid ? i_rdata : dl;
    assign alu_a = i_ctrl.alu_a_dl ? mem_data : ac;

    // High byte arriving now joined with the low byte already shifted in
    assign oper_addr = {mem_data, adr[15:8]};
    assign pc_base = {i_ctrl.ld_pch ? oper_addr[15:8] : pc[15:8],
                      i_ctrl.ld_pcl ? oper_addr[7:0] : pc[7:0]};

    cpu_alu alu_i (
        .i_op       (i_ctrl.alu_op),
        .i_a        (alu_a),
        .i_b        (mem_data),
        .i_carry    (i_ctrl.alu_cin),
        .o_result   (alu_result),
        .o_carry    (alu_carry),
        .o_overflow (alu_ovf)
    );

    always_comb begin
        case (i_ctrl.addr_src)
            ADDR_ADR: o_req.addr = oper_addr;
            ADDR_VEC_LO: o_req.addr = RESET_VECTOR;
            ADDR_VEC_HI: o_req.addr = RESET_VECTOR + addr_t'(1);
            default: o_req.addr = pc;
        endcase
        o_req.rw = ~i_ctrl.we;
        o_req.wdata = ac;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_valid <= 1'b0;
            ac <= '0;
            x <= '0;
            pc <= '0;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
            flag_v <= 1'b0;
        end else begin
            rd_valid <= i_grant && o_req.rw;
            if (i_grant) begin
                if (i_ctrl.ld_a) begin
                    ac <= alu_result;
                end
                if (i_ctrl.ld_x) begin
                    x <= alu_result;
                end
                pc <= pc_base + addr_t'(i_ctrl.pc_inc);
                if (i_ctrl.upd_nz) begin
                    flag_n <= alu_result[7];
                    flag_z <= (alu_result == 8'h00);
                end
                if (i_ctrl.set_c) begin
                    flag_c <= 1'b1;
                end else if (i_ctrl.clr_c) begin
                    flag_c <= 1'b0;
                end else if (i_ctrl.upd_c) begin
                    flag_c <= alu_carry;
                end
                if (i_ctrl.upd_v) begin
                    flag_v <= alu_ovf;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_valid) begin
            dl <= i_rdata;
        end
        if (i_grant && i_ctrl.ld_adr) begin
            adr <= oper_addr;
        end
    end

    // Unused bit 5 reads as one, as on the real part
    assign o_p = {flag_n, flag_v, 1'b1, 1'b0, 2'b00, flag_z, flag_c};

    // The instruction register sits in the decoder, the core fills ir in
    assign o_debug = '{pc: pc, ac: ac, x: x, p: o_p, ir: 8'h00};

endmodule

`default_nettype wire

// File: hw/cpu_decoder.sv
`default_nettype none

module cpu_decoder
    import cpu_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_grant,
    input  byte_t i_rdata,
    input  byte_t i_p,
    output ctrl_t o_ctrl,
    output logic  o_sync,
    output logic  o_error,
    output byte_t o_ir
);

    typedef enum logic [1:0] {
        PH_VEC_LO,
        PH_VEC_HI,
        PH_RUN,
        PH_HALT
    } phase_e;

    phase_e phase;
    step_t  step;
    byte_t  ir;
    logic   fetch_d;
    byte_t  op;
    logic   last;
    logic   bad_op;

    // The opcode is on the RAM output only in the cycle right after its fetch
    assign op = (step == step_t'(1) && fetch_d) ? i_rdata : ir;

    assign o_sync = i_grant && (phase == PH_RUN) && (step == step_t'(0));
    assign o_error = (phase == PH_HALT);
    assign o_ir = ir;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase <= PH_VEC_LO;
            step <= '0;
            ir <= '0;
            fetch_d <= 1'b0;
        end else begin
            fetch_d <= o_sync;
            if (phase == PH_VEC_HI && i_grant) begin
                // First fetch runs as the tail of a JMP through the vector
                ir <= OP_JMP_ABS;
            end else if (fetch_d) begin
                ir <= i_rdata;
            end
            case (phase)
                PH_VEC_LO: begin
                    if (i_grant) begin
                        phase <= PH_VEC_HI;
                    end
                end
                PH_VEC_HI: begin
                    if (i_grant) begin
                        phase <= PH_RUN;
                        step <= '0;
                    end
                end
                PH_RUN: begin
                    if (bad_op) begin
                        phase <= PH_HALT;
                    end else if (i_grant) begin
                        step <= last ? step_t'(0) : step + step_t'(1);
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        o_ctrl = '0;
        o_ctrl.addr_src = ADDR_PC;
        last = 1'b0;
        bad_op = 1'b0;
        case (phase)
            PH_VEC_LO: o_ctrl.addr_src = ADDR_VEC_LO;
            PH_VEC_HI: begin
                o_ctrl.addr_src = ADDR_VEC_HI;
                o_ctrl.ld_adr = 1'b1;
            end
            PH_RUN: begin
                case (step)
                    3'd0: begin
                        // Opcode fetch, finishing the previous instruction alongside
                        o_ctrl.pc_inc = 1'b1;
                        case (op)
                            OP_JMP_ABS: begin
                                o_ctrl.addr_src = ADDR_ADR;
                                o_ctrl.ld_pcl = 1'b1;
                                o_ctrl.ld_pch = 1'b1;
                            end
                            OP_LDA_IMM, OP_LDA_ABS: begin
                                o_ctrl.alu_a_dl = 1'b1;
                                o_ctrl.ld_a = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                            end
                            OP_LDX_IMM: begin
                                o_ctrl.alu_a_dl = 1'b1;
                                o_ctrl.ld_x = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                            end
                            OP_ADC_IMM: begin
                                o_ctrl.alu_op = ALU_SUM;
                                o_ctrl.alu_cin = i_p[0];
                                o_ctrl.ld_a = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                                o_ctrl.upd_c = 1'b1;
                                o_ctrl.upd_v = 1'b1;
                            end
                            OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                                o_ctrl.alu_op = (op == OP_AND_IMM) ? ALU_AND :
                                                (op == OP_ORA_IMM) ? ALU_OR : ALU_EOR;
                                o_ctrl.ld_a = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    3'd1: begin
                        case (op)
                            OP_LDA_IMM, OP_LDX_IMM, OP_ADC_IMM,
                            OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                                o_ctrl.pc_inc = 1'b1;
                                last = 1'b1;
                            end
                            OP_LSR_A: begin
                                // Carry-in of zero shifts a zero into bit 7
                                o_ctrl.alu_op = ALU_SHR;
                                o_ctrl.ld_a = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                                o_ctrl.upd_c = 1'b1;
                                last = 1'b1;
                            end
                            OP_TAX: begin
                                o_ctrl.ld_x = 1'b1;
                                o_ctrl.upd_nz = 1'b1;
                                last = 1'b1;
                            end
                            OP_CLC: begin
                                o_ctrl.clr_c = 1'b1;
                                last = 1'b1;
                            end
                            OP_SEC: begin
                                o_ctrl.set_c = 1'b1;
                                last = 1'b1;
                            end
                            OP_LDA_ABS, OP_STA_ABS, OP_JMP_ABS: o_ctrl.pc_inc = 1'b1;
                            default: bad_op = 1'b1;
                        endcase
                    end
                    3'd2: begin
                        // Low operand byte arrives, high byte is read
                        o_ctrl.ld_adr = 1'b1;
                        if (op == OP_JMP_ABS) begin
                            last = 1'b1;
                        end else begin
                            o_ctrl.pc_inc = 1'b1;
                        end
                    end
                    3'd3: begin
                        o_ctrl.addr_src = ADDR_ADR;
                        o_ctrl.we = (op == OP_STA_ABS);
                        last = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int RAM_ADDR_W = 12;

    typedef logic [15:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [2:0] step_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [1:0] addr_sel_t;

    localparam addr_t RESET_VECTOR = 16'hFFFC;

    // Request address sources
    localparam addr_sel_t ADDR_PC = 2'd0;
    localparam addr_sel_t ADDR_ADR = 2'd1;
    localparam addr_sel_t ADDR_VEC_LO = 2'd2;
    localparam addr_sel_t ADDR_VEC_HI = 2'd3;

    // Supported opcodes, standard 6502 encodings
    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'hA9,
        OP_LDA_ABS = 8'hAD,
        OP_STA_ABS = 8'h8D,
        OP_LDX_IMM = 8'hA2,
        OP_ADC_IMM = 8'h69,
        OP_AND_IMM = 8'h29,
        OP_ORA_IMM = 8'h09,
        OP_EOR_IMM = 8'h49,
        OP_LSR_A   = 8'h4A,
        OP_TAX     = 8'hAA,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_JMP_ABS = 8'h4C
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_SUM,
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_SHR
    } alu_op_e;

    typedef struct packed {
        addr_t addr;
        logic  rw;
        byte_t wdata;
    } mem_req_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
        byte_t wdata;
    } host_cmd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        // ALU A operand from memory data when set, else the accumulator
        logic      alu_a_dl;
        logic      alu_cin;
        logic      ld_a;
        logic      ld_x;
        logic      ld_pcl;
        logic      ld_pch;
        logic      ld_adr;
        logic      pc_inc;
        logic      upd_nz;
        logic      upd_c;
        logic      upd_v;
        logic      set_c;
        logic      clr_c;
        logic      we;
        addr_sel_t addr_src;
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        byte_t ac;
        byte_t x;
        byte_t p;
        byte_t ir;
    } cpu_debug_t;

endpackage

`default_nettype wire

// File: hw/cpu_system.sv
`default_nettype none

module cpu_system
    import cpu_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_run,
    input  logic       i_host_req,
    input  host_cmd_t  i_host_cmd,
    output logic       o_host_ack,
    output byte_t      o_host_rdata,
    output logic       o_sync,
    output logic       o_error,
    output cpu_debug_t o_debug
);

    mem_req_t cpu_req;
    logic     cpu_grant;
    addr_t    ram_addr;
    logic     ram_we;
    logic     ram_en;
    byte_t    ram_wdata;
    byte_t    ram_rdata;

    cpu_core core_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_grant (cpu_grant),
        .i_rdata (ram_rdata),
        .o_req   (cpu_req),
        .o_sync  (o_sync),
        .o_error (o_error),
        .o_debug (o_debug)
    );

    mem_arbiter arbiter_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_cpu_req    (cpu_req),
        .i_host_req   (i_host_req),
        .i_host_cmd   (i_host_cmd),
        .i_ram_rdata  (ram_rdata),
        .o_cpu_grant  (cpu_grant),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .o_ram_addr   (ram_addr),
        .o_ram_we     (ram_we),
        .o_ram_wdata  (ram_wdata),
        .o_ram_en     (ram_en)
    );

    // 4 KiB mirrored through the whole address space
    sys_ram ram_i (
        .i_clk   (i_clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr[RAM_ADDR_W-1:0]),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`default_nettype none

module mem_arbiter
    import cpu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_run,
    input  mem_req_t  i_cpu_req,
    input  logic      i_host_req,
    input  host_cmd_t i_host_cmd,
    input  byte_t     i_ram_rdata,
    output logic      o_cpu_grant,
    output logic      o_host_ack,
    output byte_t     o_host_rdata,
    output addr_t     o_ram_addr,
    output logic      o_ram_we,
    output byte_t     o_ram_wdata,
    output logic      o_ram_en
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_ACK,
        ST_RELEASE
    } state_e;

    state_e state;
    logic   host_go;
    logic   host_we_q;
    byte_t  host_data;
    byte_t  rdata_q;

    // Host access takes the RAM in the first cycle its request is seen
    assign host_go = (state == ST_IDLE) && i_host_req;
    assign o_cpu_grant = i_run && !host_go;

    assign o_ram_en = host_go || o_cpu_grant;
    assign o_ram_addr = host_go ? i_host_cmd.addr : i_cpu_req.addr;
    assign o_ram_we = host_go ? i_host_cmd.we : (o_cpu_grant && !i_cpu_req.rw);
    assign o_ram_wdata = host_go ? i_host_cmd.wdata : i_cpu_req.wdata;

    // Writes answer with zero
    assign host_data = host_we_q ? 8'h00 : i_ram_rdata;
    assign o_host_ack = (state == ST_ACCESS) || (state == ST_ACK);
    assign o_host_rdata = (state == ST_ACCESS) ? host_data : rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
            host_we_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_host_req) begin
                        state <= ST_ACCESS;
                        host_we_q <= i_host_cmd.we;
                    end
                end
                ST_ACCESS: state <= ST_ACK;
                ST_ACK: begin
                    if (!i_host_req) begin
                        state <= ST_RELEASE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Hold the read data while ack stays up
    always_ff @(posedge i_clk) begin
        if (state == ST_ACCESS) begin
            rdata_q <= host_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/sys_ram.sv
`default_nettype none

module sys_ram
    import cpu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_en,
    input  logic      i_we,
    input  ram_addr_t i_addr,
    input  byte_t     i_wdata,
    output byte_t     o_rdata
);

    byte_t mem [2**RAM_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/cpu_system_tb.sv
`default_nettype none

module cpu_system_tb
    import cpu_pkg::*;
#(
    parameter int SEED = 53802
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] PROG_BASE = 16'h0200;
    localparam int HOST_TIMEOUT = 50;
    localparam int RUN_TIMEOUT = 5000;

    logic       i_clk = 1'b0;
    logic       i_reset = 1'b1;
    logic       i_run = 1'b0;
    logic       i_host_req = 1'b0;
    host_cmd_t  i_host_cmd = '0;
    logic       o_host_ack;
    byte_t      o_host_rdata;
    logic       o_sync;
    logic       o_error;
    cpu_debug_t o_debug;

    logic [7:0]  model_mem [4096];
    logic [7:0]  prog [$];
    logic [15:0] stored [$];
    logic [15:0] loop_addr;
    logic [7:0]  exp_a;
    logic [7:0]  exp_x;
    logic [7:0]  exp_p;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name;

    cpu_system dut_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_host_req   (i_host_req),
        .i_host_cmd   (i_host_cmd),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .o_sync       (o_sync),
        .o_error      (o_error),
        .o_debug      (o_debug)
    );

    initial begin
        forever #5 i_clk = ~i_clk;
    end

    // Handshake rules on the host port
    ack_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_host_ack) |-> $past(i_host_req))
    else begin
        error_count++;
        test_errors++;
        $display("ack rose without a pending host request");
    end

    release_order: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_host_ack && !i_host_req) |=> !o_host_ack)
    else begin
        error_count++;
        test_errors++;
        $display("ack stayed high after the host request dropped");
    end

    rdata_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_host_ack && $past(o_host_ack)) |-> $stable(o_host_rdata))
    else begin
        error_count++;
        test_errors++;
        $display("host read data changed while ack was high");
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond) else begin
            error_count++;
            test_errors++;
            $display("%s: %s did not hold", test_name, what);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s in %s", what, test_name);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_reset <= 1'b1;
        i_run <= 1'b0;
        i_host_req <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    // Four-phase host access
    task automatic host_access(input logic [15:0] addr, input logic we,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        @(posedge i_clk);
        i_host_cmd <= '{addr: addr, we: we, wdata: wdata};
        i_host_req <= 1'b1;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            if (n > HOST_TIMEOUT) stop_on_timeout("host ack");
        end while (!o_host_ack);
        rdata = o_host_rdata;
        @(posedge i_clk);
        i_host_req <= 1'b0;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            if (n > HOST_TIMEOUT) stop_on_timeout("host ack release");
        end while (o_host_ack);
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] wr_rdata;
        host_access(addr, 1'b1, data, wr_rdata);
        model_mem[addr[11:0]] = data;
        // A write is answered with zero data
        check_val("write ack data", 32'h0, 32'(wr_rdata));
    endtask

    task automatic host_read_check(input string what, input logic [15:0] addr);
        logic [7:0] got;
        host_access(addr, 1'b0, 8'h00, got);
        check_val(what, 32'(model_mem[addr[11:0]]), 32'(got));
    endtask

    function automatic logic [7:0] mem_rd(input logic [15:0] addr);
        return model_mem[addr[11:0]];
    endfunction

    // Instruction-level model of the supported subset
    task automatic model_run(output logic [7:0] a, output logic [7:0] x, output logic [7:0] p);
        logic [15:0] pc;
        logic [15:0] t;
        logic [7:0]  op;
        logic [7:0]  b;
        logic [8:0]  s;
        logic        n;
        logic        z;
        logic        c;
        logic        v;
        logic        done;
        int          guard;
        a = 8'h00;
        x = 8'h00;
        {n, z, c, v} = 4'b0000;
        pc = {mem_rd(RESET_VECTOR + 16'd1), mem_rd(RESET_VECTOR)};
        done = 1'b0;
        guard = 0;
        while (!done && guard < 1000) begin
            guard++;
            op = mem_rd(pc);
            b = mem_rd(pc + 16'd1);
            t = {mem_rd(pc + 16'd2), b};
            case (op)
                8'hA9: a = b;
                8'hA2: x = b;
                8'hAD: a = mem_rd(t);
                8'h8D: model_mem[t[11:0]] = a;
                8'h69: begin
                    s = {1'b0, a} + {1'b0, b} + {8'h00, c};
                    v = (a[7] == b[7]) && (s[7] != a[7]);
                    c = s[8];
                    a = s[7:0];
                end
                8'h29: a = a & b;
                8'h09: a = a | b;
                8'h49: a = a ^ b;
                8'h4A: begin
                    c = a[0];
                    a = a >> 1;
                end
                8'hAA: x = a;
                8'h18: c = 1'b0;
                8'h38: c = 1'b1;
                8'h4C: begin
                    done = (t == pc);
                end
                default: done = 1'b1;
            endcase
            if (op inside {8'hA9, 8'h69, 8'h29, 8'h09, 8'h49, 8'h4A, 8'hAA}) begin
                n = a[7];
                z = (a == 8'h00);
            end
            if (op == 8'hA2 || op == 8'hAA) begin
                n = x[7];
                z = (x == 8'h00);
            end
            if (op == 8'hAD) begin
                n = a[7];
                z = (a == 8'h00);
            end
            case (op)
                8'hAD, 8'h8D: pc = pc + 16'd3;
                8'h4C: pc = t;
                8'h4A, 8'hAA, 8'h18, 8'h38: pc = pc + 16'd1;
                default: pc = pc + 16'd2;
            endcase
        end
        p = {n, v, 1'b1, 1'b0, 2'b00, z, c};
    endtask

    task automatic emit(input logic [7:0] b);
        prog.push_back(b);
    endtask

    task automatic emit_store(input logic [15:0] addr);
        emit(8'h8D);
        emit(addr[7:0]);
        emit(addr[15:8]);
        stored.push_back(addr);
    endtask

    task automatic emit_jmp_self();
        loop_addr = PROG_BASE + 16'(prog.size());
        emit(8'h4C);
        emit(loop_addr[7:0]);
        emit(loop_addr[15:8]);
    endtask

    // Random operands through every ALU opcode, each result stored
    task automatic build_alu_prog();
        prog.delete();
        stored.delete();
        emit(8'hA9);
        emit(8'($urandom));
        emit(8'h18);
        emit(8'h69);
        emit(8'($urandom));
        emit_store(16'h0320);
        emit(8'h38);
        emit(8'h69);
        emit(8'($urandom));
        emit_store(16'h0321);
        emit(8'h29);
        emit(8'($urandom));
        emit_store(16'h0322);
        emit(8'h09);
        emit(8'($urandom));
        emit_store(16'h0323);
        emit(8'h49);
        emit(8'($urandom));
        emit_store(16'h0324);
        emit(8'h4A);
        emit_store(16'h0325);
        emit(8'h18);
        emit(8'h69);
        emit(8'($urandom));
        emit_store(16'h0326);
        emit_jmp_self();
    endtask

    task automatic load_and_predict();
        foreach (prog[i]) begin
            host_write(PROG_BASE + 16'(i), prog[i]);
        end
        host_write(RESET_VECTOR, PROG_BASE[7:0]);
        host_write(RESET_VECTOR + 16'd1, PROG_BASE[15:8]);
        model_run(exp_a, exp_x, exp_p);
        @(posedge i_clk);
        i_run <= 1'b1;
    endtask

    // Two fetches of the self-jump mark the end of the program
    // PC reads one past the opcode once its fetch cycle is over
    task automatic wait_for_loop();
        int   n;
        int   hits;
        logic fetched;
        n = 0;
        hits = 0;
        fetched = 1'b0;
        while (hits < 2) begin
            @(negedge i_clk);
            n++;
            if (n > RUN_TIMEOUT) stop_on_timeout("the program loop");
            if (fetched && o_debug.pc == loop_addr + 16'd1) hits++;
            fetched = o_sync;
        end
    endtask

    task automatic check_results();
        foreach (stored[i]) begin
            host_read_check($sformatf("mem[%0h]", stored[i]), stored[i]);
        end
        check_val("A", 32'(exp_a), 32'(o_debug.ac));
        check_val("X", 32'(exp_x), 32'(o_debug.x));
        check_val("NVZC", 32'(exp_p & 8'hC3), 32'(o_debug.p & 8'hC3));
        // The self-jump keeps its opcode in IR
        check_val("IR", 32'h4C, 32'(o_debug.ir));
    endtask

    task automatic host_traffic();
        repeat (10) begin
            repeat ($urandom_range(0, 5)) @(posedge i_clk);
            host_read_check("traffic read", 16'h0900 + 16'($urandom_range(0, 7)));
        end
    endtask

    initial begin
        logic [15:0] addrs [16];
        logic [15:0] pc_hold;
        int n;
        void'($urandom(SEED));

        start_test("reset_state");
        apply_reset();
        repeat (20) begin
            @(negedge i_clk);
            check_true("ack low", !o_host_ack);
            check_true("sync low", !o_sync);
            check_true("error low", !o_error);
        end
        finish_test();

        start_test("host_readback");
        foreach (addrs[i]) begin
            addrs[i] = 16'($urandom_range(16'h0400, 16'h0FFB));
            host_write(addrs[i], 8'($urandom));
        end
        foreach (addrs[i]) begin
            host_read_check($sformatf("mem[%0h]", addrs[i]), addrs[i]);
        end
        finish_test();

        start_test("load_store");
        apply_reset();
        prog.delete();
        stored.delete();
        host_write(16'h0310, 8'($urandom));
        emit(8'hA9);
        emit(8'($urandom));
        emit_store(16'h0300);
        emit(8'hA2);
        emit(8'($urandom));
        emit(8'hAD);
        emit(8'h10);
        emit(8'h03);
        emit(8'hAA);
        emit_store(16'h0301);
        emit(8'hA9);
        emit(8'($urandom));
        emit_store(16'h0302);
        emit_jmp_self();
        load_and_predict();
        wait_for_loop();
        check_results();
        finish_test();

        start_test("alu_flags");
        apply_reset();
        build_alu_prog();
        load_and_predict();
        wait_for_loop();
        check_results();
        finish_test();

        start_test("shared_memory");
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            host_write(16'h0900 + 16'(i), 8'($urandom));
        end
        build_alu_prog();
        load_and_predict();
        fork
            wait_for_loop();
            host_traffic();
        join
        check_results();
        finish_test();

        start_test("bad_opcode");
        apply_reset();
        prog.delete();
        stored.delete();
        emit(8'hA9);
        emit(8'h01);
        emit(8'h02);
        emit_jmp_self();
        load_and_predict();
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            if (n > RUN_TIMEOUT) stop_on_timeout("the error flag");
        end while (!o_error);
        check_val("IR", 32'h02, 32'(o_debug.ir));
        pc_hold = o_debug.pc;
        repeat (20) begin
            @(negedge i_clk);
            check_true("sync low after error", !o_sync);
            check_val("pc hold", 32'(pc_hold), 32'(o_debug.pc));
        end
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
